// File: rtl/vec_pkg.sv
`default_nettype none

package vec_pkg;

    ////////////////////
    // Geometry

    // Lanes per vector
    localparam int LANES = 40;

    // Lanes per output beat, must divide LANES
    localparam int OUT_WIDTH = 8;

    // Output beats per vector
    localparam int OUT_BEATS = LANES / OUT_WIDTH;

    ////////////////////
    // Data types

    // Signed 16-bit fixed-point lane
    typedef logic signed [15:0] lane_t;

    // Activation opcodes
    typedef enum logic [1:0] {
        ACT_PASS       = 2'd0,
        ACT_RELU       = 2'd1,
        ACT_SCALE      = 2'd2,
        ACT_SCALE_RELU = 2'd3
    } act_op_e;

    // Per-vector activation config, 14 bits
    typedef struct packed {
        act_op_e            op;
        logic signed [7:0]  scale;
        logic        [3:0]  shift;
    } act_cfg_t;

    // Full vector, lane 0 is the first word received
    typedef struct packed {
        lane_t [LANES-1:0] lanes;
        act_cfg_t          cfg;
    } vec_t;

endpackage

`default_nettype wire

// File: rtl/reshape_input.sv
`timescale 1ns/1ns
`default_nettype none

module reshape_input (
    input  logic              clk,
    input  logic              reset,

    input  vec_pkg::lane_t    in_word,
    input  vec_pkg::act_cfg_t in_cfg,
    input  logic              in_valid,
    output logic              in_ready,

    output vec_pkg::vec_t     gather_vec,
    output logic              gather_valid,
    input  logic              gather_ready
);
    import vec_pkg::*;

    logic [5:0]        lane_cnt;
    logic              full;
    lane_t [LANES-1:0] lanes_q;
    act_cfg_t          cfg_q;
    logic              accept;
    logic              last_word;
    logic              hand_off;

    // Stall the input while a complete vector waits downstream
    assign in_ready  = !full;
    assign accept    = in_valid && in_ready;
    assign last_word = (lane_cnt == 6'(LANES - 1));
    assign hand_off  = gather_valid && gather_ready;

    assign gather_valid     = full;
    assign gather_vec.lanes = lanes_q;
    assign gather_vec.cfg   = cfg_q;

    ////////////////////
    // Control

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            lane_cnt <= 6'd0;
            full     <= 1'b0;
        end else if (hand_off) begin
            lane_cnt <= 6'd0;
            full     <= 1'b0;
        end else if (accept) begin
            if (last_word) begin
                // Counter holds at the last lane until hand-off
                full <= 1'b1;
            end else begin
                lane_cnt <= lane_cnt + 6'd1;
            end
        end
    end

    ////////////////////
    // Payload

    always_ff @(posedge clk) begin
        if (accept) begin
            lanes_q[lane_cnt] <= in_word;
            // Config only counts on the closing word
            if (last_word) begin
                cfg_q <= in_cfg;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/vector_activation.sv
`timescale 1ns/1ns
`default_nettype none

module vector_activation (
    input  logic                                   clk,
    input  logic                                   reset,

    input  vec_pkg::vec_t                          s_vec,
    input  logic                                   s_valid,
    output logic                                   s_ready,

    output vec_pkg::lane_t [vec_pkg::LANES-1:0]    m_lanes,
    output logic                                   m_valid,
    input  logic                                   m_ready
);
    import vec_pkg::*;

    lane_t [LANES-1:0] result;
    logic              accept;

    // Clamp a 24-bit value into the 16-bit lane range
    function automatic lane_t saturate(logic signed [23:0] value);
        lane_t clamped;
        if (value > 24'sd32767) begin
            clamped = 16'sh7fff;
        end else if (value < -24'sd32768) begin
            clamped = 16'sh8000;
        end else begin
            clamped = value[15:0];
        end
        return clamped;
    endfunction

    // Lane-wise activation for one config
    function automatic lane_t activate(lane_t x, act_cfg_t cfg);
        logic signed [23:0] prod;
        logic signed [23:0] shifted;
        lane_t              scaled;
        lane_t              y;
        prod    = x * $signed(cfg.scale);
        shifted = prod >>> cfg.shift;
        scaled  = saturate(shifted);
        unique case (cfg.op)
            ACT_PASS:       y = x;
            ACT_RELU:       y = x[15] ? 16'sd0 : x;
            ACT_SCALE:      y = scaled;
            ACT_SCALE_RELU: y = scaled[15] ? 16'sd0 : scaled;
            default:        y = x;
        endcase
        return y;
    endfunction

    ////////////////////
    // Datapath

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            result[i] = activate(s_vec.lanes[i], s_vec.cfg);
        end
    end

    // One-entry stage, refills in the same cycle it drains
    assign s_ready = !m_valid || m_ready;
    assign accept  = s_valid && s_ready;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            m_valid <= 1'b0;
        end else if (accept) begin
            m_valid <= 1'b1;
        end else if (m_ready) begin
            m_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            m_lanes <= result;
        end
    end

endmodule

`default_nettype wire

// File: rtl/reshape_output.sv
`timescale 1ns/1ns
`default_nettype none

module reshape_output #(
    parameter int OUT_WIDTH = vec_pkg::OUT_WIDTH
) (
    input  logic                                   clk,
    input  logic                                   reset,

    input  vec_pkg::lane_t [vec_pkg::LANES-1:0]    in_lanes,
    input  logic                                   s_valid,
    output logic                                   s_ready,

    output vec_pkg::lane_t [OUT_WIDTH-1:0]         out_beat,
    output logic                                   m_valid,
    output logic                                   m_last,
    input  logic                                   m_ready
);
    import vec_pkg::*;

    // Rows per vector for this beat width
    localparam int NUM_ROWS = LANES / OUT_WIDTH;

    lane_t [OUT_WIDTH-1:0] rows [NUM_ROWS];
    logic [5:0]            beat_cnt;
    logic                  held;
    logic                  load;
    logic                  advance;
    logic                  final_beat;

    assign s_ready    = !held;
    assign load       = s_valid && s_ready;
    assign advance    = held && m_ready;
    assign final_beat = (beat_cnt == 6'(NUM_ROWS - 1));

    assign m_valid  = held;
    assign m_last   = held && final_beat;
    assign out_beat = rows[0];

    ////////////////////
    // Beat control

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            held     <= 1'b0;
            beat_cnt <= 6'd0;
        end else if (load) begin
            held     <= 1'b1;
            beat_cnt <= 6'd0;
        end else if (advance) begin
            if (final_beat) begin
                held <= 1'b0;
            end else begin
                beat_cnt <= beat_cnt + 6'd1;
            end
        end
    end

    ////////////////////
    // Row bank

    always_ff @(posedge clk) begin
        if (load) begin
            for (int r = 0; r < NUM_ROWS; r++) begin
                for (int c = 0; c < OUT_WIDTH; c++) begin
                    rows[r][c] <= in_lanes[r * OUT_WIDTH + c];
                end
            end
        end else if (advance) begin
            // Next row moves into the output slot
            for (int r = 0; r < NUM_ROWS - 1; r++) begin
                rows[r] <= rows[r + 1];
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/vector_pipe_top.sv
`timescale 1ns/1ns
`default_nettype none

module vector_pipe_top (
    input  logic                                   clk,
    input  logic                                   reset,

    input  vec_pkg::lane_t                         in_word,
    input  vec_pkg::act_cfg_t                      in_cfg,
    input  logic                                   in_valid,
    output logic                                   in_ready,

    output vec_pkg::lane_t [vec_pkg::OUT_WIDTH-1:0] out_beat,
    output logic                                   out_valid,
    output logic                                   out_last,
    input  logic                                   out_ready
);
    import vec_pkg::*;

    // Gather to activation
    vec_t              gather_vec;
    logic              gather_valid;
    logic              gather_ready;

    // Activation to output
    lane_t [LANES-1:0] act_lanes;
    logic              act_valid;
    logic              act_ready;

    reshape_input reshape_input_inst (
        .clk          (clk),
        .reset        (reset),
        .in_word      (in_word),
        .in_cfg       (in_cfg),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .gather_vec   (gather_vec),
        .gather_valid (gather_valid),
        .gather_ready (gather_ready)
    );

    vector_activation vector_activation_inst (
        .clk     (clk),
        .reset   (reset),
        .s_vec   (gather_vec),
        .s_valid (gather_valid),
        .s_ready (gather_ready),
        .m_lanes (act_lanes),
        .m_valid (act_valid),
        .m_ready (act_ready)
    );

    reshape_output #(
        .OUT_WIDTH (OUT_WIDTH)
    ) reshape_output_inst (
        .clk      (clk),
        .reset    (reset),
        .in_lanes (act_lanes),
        .s_valid  (act_valid),
        .s_ready  (act_ready),
        .out_beat (out_beat),
        .m_valid  (out_valid),
        .m_last   (out_last),
        .m_ready  (out_ready)
    );

endmodule

`default_nettype wire

// File: bench/vector_pipe_properties.sv
`timescale 1ns/1ns
`default_nettype none

module vector_pipe_properties (
    input logic                                    clk,
    input logic                                    reset,
    input logic                                    in_ready,
    input vec_pkg::lane_t [vec_pkg::OUT_WIDTH-1:0] out_beat,
    input logic                                    out_valid,
    input logic                                    out_last,
    input logic                                    out_ready
);

    // Output beat holds while the sink stalls
    stall_hold: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_beat))
        else $error("output beat changed while stalled");

    // Output stage drains once the closing beat transfers
    last_framing: assert property (@(posedge clk) disable iff (reset)
        out_valid && out_ready && out_last |=> !out_valid)
        else $error("output not empty after the closing beat");

    // First cycle out of reset
    reset_state: assert property (@(posedge clk)
        $fell(reset) |-> in_ready && !out_valid)
        else $error("wrong handshake state after reset");

    known_flags: assert property (@(posedge clk) disable iff (reset)
        !$isunknown({in_ready, out_valid, out_last}))
        else $error("unknown value on a handshake output");

    known_beat: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> !$isunknown(out_beat))
        else $error("unknown value on a valid output beat");

endmodule

bind vector_pipe_top vector_pipe_properties vector_pipe_properties_inst (
    .clk       (clk),
    .reset     (reset),
    .in_ready  (in_ready),
    .out_beat  (out_beat),
    .out_valid (out_valid),
    .out_last  (out_last),
    .out_ready (out_ready)
);

`default_nettype wire

// File: bench/vector_pipe_tb.sv
`timescale 1ns/1ns
`default_nettype none

module vector_pipe_tb;
    import vec_pkg::*;

    localparam int NUM_VECTORS     = 60;
    localparam int TOTAL_BEATS     = NUM_VECTORS * OUT_BEATS;
    localparam int CLK_PERIOD      = 20;
    localparam int WATCHDOG_CYCLES = NUM_VECTORS * LANES * 8;

    typedef lane_t [OUT_WIDTH-1:0] beat_t;

    logic     clk;
    logic     reset;
    lane_t    in_word;
    act_cfg_t in_cfg;
    logic     in_valid;
    logic     in_ready;
    beat_t    out_beat;
    logic     out_valid;
    logic     out_last;
    logic     out_ready;

    integer seed;
    int     error_count;
    int     check_count;
    int     out_count;
    int     vec_idx;
    int     word_idx;
    int     low_stretch;
    logic   run_stim;
    logic   in_fire;
    lane_t  words [LANES];
    beat_t  exp_q [$];

    vector_pipe_top vector_pipe_top_inst (
        .clk       (clk),
        .reset     (reset),
        .in_word   (in_word),
        .in_cfg    (in_cfg),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_beat  (out_beat),
        .out_valid (out_valid),
        .out_last  (out_last),
        .out_ready (out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////
    // Helpers

    function automatic int random_below(int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // Config carried by the closing word of vector v
    function automatic act_cfg_t closing_cfg(int v);
        act_cfg_t cfg;
        cfg = 14'($random(seed));
        if (v < 4) begin
            cfg.op = act_op_e'(v[1:0]);
        end
        // Every tenth vector gets a full-scale multiply with no shift
        if (v % 10 == 9) begin
            cfg.op    = ACT_SCALE;
            cfg.scale = -8'sd128;
            cfg.shift = 4'd0;
        end
        return cfg;
    endfunction

    // Reference activation for one lane
    function automatic lane_t expected_lane(lane_t x, act_cfg_t cfg);
        int value;
        value = x;
        if (cfg.op == ACT_SCALE || cfg.op == ACT_SCALE_RELU) begin
            value = (value * int'(cfg.scale)) >>> cfg.shift;
            if (value > 32767) begin
                value = 32767;
            end else if (value < -32768) begin
                value = -32768;
            end
        end
        if ((cfg.op == ACT_RELU || cfg.op == ACT_SCALE_RELU) && value < 0) begin
            value = 0;
        end
        return lane_t'(value);
    endfunction

    // Queue the expected beats of the vector in words
    task automatic push_expected(input act_cfg_t cfg);
        beat_t beat;
        for (int b = 0; b < OUT_BEATS; b++) begin
            for (int c = 0; c < OUT_WIDTH; c++) begin
                beat[c] = expected_lane(words[b * OUT_WIDTH + c], cfg);
            end
            exp_q.push_back(beat);
        end
    endtask

    task automatic check_equal(input logic [127:0] actual, input logic [127:0] expected,
                               input string what);
        check_count = check_count + 1;
        if (actual !== expected) begin
            error_count = error_count + 1;
            $display("ERR %0t ns: %s, got %0h, expected %0h", $time, what, actual, expected);
        end
    endtask

    ////////////////////
    // Stimulus

    always @(posedge clk) begin
        if (run_stim) begin
            if (in_fire) begin
                words[word_idx] = in_word;
                if (word_idx == LANES - 1) begin
                    push_expected(in_cfg);
                    vec_idx  = vec_idx + 1;
                    word_idx = 0;
                end else begin
                    word_idx = word_idx + 1;
                end
            end
            // New word only once the previous one has transferred
            if (!in_valid || in_fire) begin
                if (vec_idx < NUM_VECTORS && random_below(4) != 0) begin
                    in_valid <= 1'b1;
                    in_word  <= lane_t'($random(seed));
                    if (word_idx == LANES - 1) begin
                        in_cfg <= closing_cfg(vec_idx);
                    end else begin
                        in_cfg <= 14'($random(seed));
                    end
                end else begin
                    in_valid <= 1'b0;
                end
            end
            // Sink side, with occasional long stalls
            if (low_stretch > 0) begin
                low_stretch = low_stretch - 1;
                out_ready <= 1'b0;
            end else if (random_below(16) == 0) begin
                low_stretch = 2 + random_below(8);
                out_ready <= 1'b0;
            end else begin
                out_ready <= (random_below(10) < 6);
            end
        end
    end

    ////////////////////
    // Scoreboard

    always @(negedge clk) begin
        in_fire = in_valid && in_ready;
        if (!reset && out_valid && out_ready) begin
            out_count = out_count + 1;
            check_equal(exp_q.size() > 0, 1'b1, "output beat with no vector expected");
            if (exp_q.size() > 0) begin
                check_equal(out_beat, exp_q.pop_front(), "output beat");
            end
            check_equal(out_last, (out_count % OUT_BEATS) == 0, "out_last framing");
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: run ended before all vectors came out (%0d of %0d beats)",
                 out_count, TOTAL_BEATS);
        $display("Checks: %0d  Errors: %0d", check_count, error_count);
        $display("Test failures found");
        $finish;
    end

    initial begin
        seed        = 32'h8be7;
        reset       = 1'b1;
        in_word     = '0;
        in_cfg      = '0;
        in_valid    = 1'b0;
        out_ready   = 1'b0;
        run_stim    = 1'b0;
        in_fire     = 1'b0;
        error_count = 0;
        check_count = 0;
        out_count   = 0;
        vec_idx     = 0;
        word_idx    = 0;
        low_stretch = 0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_equal(in_ready, 1'b1, "in_ready after reset");
        check_equal(out_valid, 1'b0, "out_valid after reset");
        run_stim = 1'b1;
        wait (out_count == TOTAL_BEATS);
        // Settle window to catch any extra beat
        repeat (50) @(posedge clk);
        check_equal(out_count, TOTAL_BEATS, "total output beats");
        check_equal(exp_q.size(), 0, "expected beats left over");
        $display("Checks: %0d  Errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
rtl/vec_pkg.sv
rtl/reshape_input.sv
rtl/vector_activation.sv
rtl/reshape_output.sv
rtl/vector_pipe_top.sv
bench/vector_pipe_properties.sv
bench/vector_pipe_tb.sv

// File: Makefile
SIM = obj_dir/vector_pipe_sim

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module vector_pipe_tb \
		-f build.f -Mdir obj_dir -o vector_pipe_sim

run: compile
	./$(SIM) | tee sim.log
	grep -q 'All tests passed!' sim.log

clean:
	rm -rf obj_dir sim.log
